// ==== test/binned_memory_stimulus.hex ====
// test_op_chk_page_bin_slot_count_data_expdoutb_expnent, one record per line
// op bits: 0 data write, 1 count write, 2 read, 3 regceb low, 4 rstb
// reset state
1_08_1_0_0_0_0_0000_0000_0
1_0C_1_5_2_3_0_0000_0000_0
1_04_2_7_7_F_0_0000_0000_0
// write then read
2_01_0_1_2_3_0_1234_0000_0
2_01_0_6_0_0_0_3ABC_0000_0
2_01_0_7_7_F_0_0F0F_0000_0
2_01_0_0_5_9_0_2001_0000_0
2_04_2_1_2_3_0_0000_1234_0
2_04_2_6_0_0_0_0000_3ABC_0
2_04_2_7_7_F_0_0000_0F0F_0
2_04_2_0_5_9_0_0000_2001_0
// entry counts
3_02_0_1_2_0_5_0000_0000_0
3_02_0_6_0_0_C_0000_0000_0
3_02_0_0_5_0_3_0000_0000_0
3_04_2_1_2_3_0_0000_1234_5
3_04_2_6_0_0_0_0000_3ABC_C
3_04_2_0_5_9_0_0000_2001_3
3_04_2_2_4_1_0_0000_0000_0
// same-cycle ordering
4_05_2_1_2_3_0_2222_1234_5
4_04_2_1_2_3_0_0000_2222_5
4_06_2_1_2_3_9_0000_2222_5
4_04_2_1_2_3_0_0000_2222_9
// stalls
5_04_2_6_0_0_0_0000_3ABC_C
5_00_0_0_0_0_0_0000_0000_0
5_04_0_0_5_9_0_0000_0000_0
5_08_1_0_0_0_0_0000_3ABC_C
5_08_1_0_0_0_0_0000_3ABC_C
5_00_1_0_0_0_0_0000_2001_3
5_00_1_0_0_0_0_0000_2001_3
// count reset
6_10_1_0_0_0_0_0000_0000_0
6_10_1_0_0_0_0_0000_0000_0
6_04_2_1_2_3_0_0000_2222_0
6_04_2_6_0_0_0_0000_3ABC_0
6_04_2_0_5_9_0_0000_2001_0
6_02_0_0_5_0_2_0000_0000_0
6_04_2_0_5_9_0_0000_2001_2

// ==== project.f ====
logic/binned_memory_pkg.sv
logic/bin_data_ram.sv
logic/bin_count_table.sv
logic/read_output_stage.sv
logic/binned_memory.sv
test/binned_memory_props.sv
test/tb_binned_memory.sv

// ==== Bender.yml ====
package:
  name: binned_memory

sources:
  - logic/binned_memory_pkg.sv
  - logic/bin_data_ram.sv
  - logic/bin_count_table.sv
  - logic/read_output_stage.sv
  - logic/binned_memory.sv
  - target: test
    files:
      - test/binned_memory_props.sv
      - test/tb_binned_memory.sv

// ==== test/tb_binned_memory.sv ====
`timescale 1ns/1ps

module tb_binned_memory;

  localparam int RAM_WIDTH = 14;             // Barrel PS layer
  localparam int MAX_REC   = 64;             // Room in the record array
  localparam int REC_W     = 68;             // 17 hex digits per record

  // Bit positions in the op field
  localparam int OP_WEA  = 0;                // Data write
  localparam int OP_CNT  = 1;                // Count write
  localparam int OP_ENB  = 2;                // Read issue
  localparam int OP_HOLD = 3;                // regceb low
  localparam int OP_RST  = 4;                // rstb high

  typedef struct packed {
    logic [3:0]  test;                       // Behaviour number
    logic [7:0]  op;                         // Strobe flags
    logic [3:0]  chk;                        // Cycles to compare, 0 for none
    logic [3:0]  page;
    logic [3:0]  bin;
    logic [3:0]  slot;
    logic [3:0]  count;                      // Count write value
    logic [15:0] data;                       // Data write value
    logic [15:0] exp_dout;                   // Expected doutb
    logic [3:0]  exp_nent;                   // Expected nent_out
  } stim_rec_t;

  //////////////////////////////////////////////////
  // DUT and bound checks
  //////////////////////////////////////////////////

  logic                                  clkb;
  logic                                  rstb;
  logic                                  wea;
  binned_memory_pkg::mem_addr_t          addra;
  logic [RAM_WIDTH-1:0]                  dina;
  binned_memory_pkg::count_wr_t          count_wr;
  logic                                  enb;
  binned_memory_pkg::mem_addr_t          addrb;
  logic                                  regceb;
  logic [RAM_WIDTH-1:0]                  doutb;
  logic [binned_memory_pkg::COUNT_W-1:0] nent_out;

  binned_memory #(
    .RAM_WIDTH (RAM_WIDTH)
  ) dut_i (
    .clkb     (clkb),
    .rstb     (rstb),
    .wea      (wea),
    .addra    (addra),
    .dina     (dina),
    .count_wr (count_wr),
    .enb      (enb),
    .addrb    (addrb),
    .regceb   (regceb),
    .doutb    (doutb),
    .nent_out (nent_out)
  );

  bind binned_memory binned_memory_props props_i (
    .clkb     (clkb),
    .rstb     (rstb),
    .regceb   (regceb),
    .doutb    (doutb),
    .nent_out (nent_out)
  );

  //////////////////////////////////////////////////
  // Records and bookkeeping
  //////////////////////////////////////////////////

  logic [REC_W-1:0] recs [MAX_REC];          // Raw stimulus
  logic             due_valid [MAX_REC+16];  // Compare scheduled at this cycle
  int               due_rec [MAX_REC+16];    // Record whose result is due
  logic             test_used [16];
  int               test_done_cyc [16];      // Cycle of last compare per test
  int               test_checks [16];
  int               test_errors [16];
  int               n_rec;
  int               last_cyc;
  int               check_count   = 0;
  int               fail_count    = 0;
  int               tests_passed  = 0;
  int               tests_failed  = 0;
  int               cycles        = 0;
  int               timeout_limit = 50;

  initial begin
    clkb = 1'b0;
    forever #50 clkb = ~clkb;                // 100 ns period
  end

  always @(posedge clkb) begin
    cycles++;
    if (cycles >= timeout_limit) begin
      $display("timeout: replay still running after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic string test_name(input logic [3:0] t);
    case (t)
      4'd1:    return "reset state";
      4'd2:    return "write then read";
      4'd3:    return "entry counts";
      4'd4:    return "same-cycle ordering";
      4'd5:    return "stalls";
      4'd6:    return "count reset";
      default: return "unnamed";
    endcase
  endfunction

  task automatic count_records();
    n_rec = 0;
    while (n_rec < MAX_REC && recs[n_rec][REC_W-1 -: 4] != 4'd0) begin
      n_rec++;                               // Test 0 marks the end
    end
  endtask

  // Turn each record's chk into a compare slot and find when each test ends
  task automatic schedule_checks();
    stim_rec_t r;
    int        done_cyc;
    for (int i = 0; i < MAX_REC + 16; i++) begin
      due_valid[i] = 1'b0;
      due_rec[i]   = 0;
    end
    for (int t = 0; t < 16; t++) begin
      test_used[t]     = 1'b0;
      test_done_cyc[t] = 0;
      test_checks[t]   = 0;
      test_errors[t]   = 0;
    end
    last_cyc = 0;
    for (int k = 0; k < n_rec; k++) begin
      r = recs[k];
      if (r.chk != 0) begin
        if (due_valid[k + r.chk]) begin
          $display("stimulus records %0d and %0d compare in the same cycle",
                   due_rec[k + r.chk], k);
          fail_count++;
        end
        due_valid[k + r.chk] = 1'b1;
        due_rec[k + r.chk]   = k;
      end
      done_cyc          = k + ((r.chk != 0) ? int'(r.chk) : 1);
      test_used[r.test] = 1'b1;
      if (done_cyc > test_done_cyc[r.test]) begin
        test_done_cyc[r.test] = done_cyc;
      end
      if (done_cyc > last_cyc) begin
        last_cyc = done_cyc;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Drive and compare
  //////////////////////////////////////////////////

  task automatic drive_record(input int k);
    stim_rec_t r;
    r              = recs[k];
    rstb           = r.op[OP_RST];
    wea            = r.op[OP_WEA];
    addra          = {r.page[binned_memory_pkg::PAGE_W-1:0],
                      r.bin[binned_memory_pkg::BIN_W-1:0],
                      r.slot[binned_memory_pkg::SLOT_W-1:0]};
    dina           = r.data[RAM_WIDTH-1:0];
    count_wr.we    = r.op[OP_CNT];
    count_wr.page  = r.page[binned_memory_pkg::PAGE_W-1:0];
    count_wr.bin   = r.bin[binned_memory_pkg::BIN_W-1:0];
    count_wr.count = r.count;
    enb            = r.op[OP_ENB];
    addrb          = addra;                  // Reads and writes share the fields
    regceb         = !r.op[OP_HOLD];
  endtask

  task automatic drive_idle();
    rstb     = 1'b0;
    wea      = 1'b0;
    count_wr = '0;
    enb      = 1'b0;
    regceb   = 1'b1;                         // Drains reads still in flight
  endtask

  task automatic compare_outputs(input int cyc);
    stim_rec_t r;
    if (due_valid[cyc]) begin
      r = recs[due_rec[cyc]];
      test_checks[r.test] += 2;
      check_count         += 2;
      if (doutb !== r.exp_dout[RAM_WIDTH-1:0]) begin
        $display("ERROR test %0d record %0d: doutb expected %h, got %h",
                 r.test, due_rec[cyc], r.exp_dout[RAM_WIDTH-1:0], doutb);
        test_errors[r.test]++;
        fail_count++;
      end
      if (nent_out !== r.exp_nent) begin
        $display("ERROR test %0d record %0d: nent_out expected %h, got %h",
                 r.test, due_rec[cyc], r.exp_nent, nent_out);
        test_errors[r.test]++;
        fail_count++;
      end
    end
  endtask

  task automatic report_finished_tests(input int cyc);
    for (int t = 1; t < 16; t++) begin
      if (test_used[t] && test_done_cyc[t] == cyc) begin
        if (test_errors[t] == 0) begin
          tests_passed++;
          $display("test %0d %s: pass, %0d compares", t, test_name(t), test_checks[t]);
        end else begin
          tests_failed++;
          $display("test %0d %s: fail, %0d of %0d compares wrong",
                   t, test_name(t), test_errors[t], test_checks[t]);
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Replay
  //////////////////////////////////////////////////

  initial begin
    rstb     = 1'b1;                         // Held over the first two edges
    wea      = 1'b0;
    addra    = '0;
    dina     = '0;
    count_wr = '0;
    enb      = 1'b0;
    addrb    = '0;
    regceb   = 1'b0;
    for (int i = 0; i < MAX_REC; i++) begin
      recs[i] = '0;
    end
    $readmemh("test/binned_memory_stimulus.hex", recs);
    count_records();
    timeout_limit = 4 * n_rec + 50;
    schedule_checks();
    if (n_rec == 0) begin
      $display("stimulus file holds no records");
      fail_count++;
    end
    repeat (2) @(posedge clkb);
    for (int cyc = 0; cyc <= last_cyc; cyc++) begin
      @(negedge clkb);                       // Outputs settled, inputs change here
      compare_outputs(cyc);
      report_finished_tests(cyc);
      if (cyc < n_rec) begin
        drive_record(cyc);
      end else begin
        drive_idle();
      end
    end
    $display("summary: %0d compares ok, %0d bad, %0d tests ok, %0d bad, %0d assert fails",
             check_count - fail_count, fail_count, tests_passed, tests_failed,
             dut_i.props_i.assert_fails);
    if (fail_count == 0 && tests_failed == 0 && dut_i.props_i.assert_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== test/binned_memory_props.sv ====
`timescale 1ns/1ps

module binned_memory_props (
  input logic                                  clkb,     // DUT clock
  input logic                                  rstb,     // DUT sync reset
  input logic                                  regceb,   // Output register enable
  input logic [13:0]                           doutb,    // Barrel PS word width
  input logic [binned_memory_pkg::COUNT_W-1:0] nent_out  // Bin entry count
);

  int assert_fails = 0;                      // Failed assertions so far

  //////////////////////////////////////////////////
  // Output register behaviour
  //////////////////////////////////////////////////

  // Reset wins over regceb, so both outputs read zero one edge later
  reset_clears_outputs: assert property (
    @(posedge clkb) rstb |=> (doutb == '0 && nent_out == '0)
  ) else begin
    $error("doutb or nent_out not zero in the cycle after rstb");
    assert_fails++;
  end

  // Downstream stall, word and count frozen together
  hold_keeps_outputs: assert property (
    @(posedge clkb) (!regceb && !rstb) |=> ($stable(doutb) && $stable(nent_out))
  ) else begin
    $error("doutb or nent_out moved while regceb was low");
    assert_fails++;
  end

endmodule

// ==== logic/binned_memory.sv ====
`timescale 1ns/1ps

module binned_memory #(
  parameter int RAM_WIDTH = 14               // Per-layer stub word width
) (
  input  logic                                  clkb,      // Single clock for both ports
  input  logic                                  rstb,      // Sync reset, active high

  // Data write side
  input  logic                                  wea,       // Write enable
  input  binned_memory_pkg::mem_addr_t          addra,     // Page, bin, slot
  input  logic [RAM_WIDTH-1:0]                  dina,      // Stub word

  // Count write side
  input  binned_memory_pkg::count_wr_t          count_wr,  // Set count of one bin

  // Read side
  input  logic                                  enb,       // Stage one enable
  input  binned_memory_pkg::mem_addr_t          addrb,     // Page, bin, slot
  input  logic                                  regceb,    // Stage two enable
  output logic [RAM_WIDTH-1:0]                  doutb,     // Stub word out
  output logic [binned_memory_pkg::COUNT_W-1:0] nent_out   // Bin entry count out
);

  //////////////////////////////////////////////////
  // Stage one results
  //////////////////////////////////////////////////

  logic [RAM_WIDTH-1:0]                  ram_data;   // RAM word after one cycle
  logic [binned_memory_pkg::COUNT_W-1:0] bin_count;  // Count after one cycle

  //////////////////////////////////////////////////
  // Data RAM and count table side by side
  //////////////////////////////////////////////////

  bin_data_ram #(
    .RAM_WIDTH (RAM_WIDTH)
  ) ram_i (
    .clkb     (clkb),
    .wea      (wea),
    .addra    (addra),
    .dina     (dina),
    .enb      (enb),
    .addrb    (addrb),
    .ram_data (ram_data)
  );

  bin_count_table count_i (
    .clkb      (clkb),
    .rstb      (rstb),
    .count_wr  (count_wr),
    .enb       (enb),
    .addrb     (addrb),                      // Only page and bin used
    .bin_count (bin_count)
  );

  //////////////////////////////////////////////////
  // Output stage joins both
  //////////////////////////////////////////////////

  read_output_stage #(
    .RAM_WIDTH (RAM_WIDTH)
  ) out_i (
    .clkb      (clkb),
    .rstb      (rstb),
    .regceb    (regceb),
    .ram_data  (ram_data),
    .bin_count (bin_count),
    .doutb     (doutb),
    .nent_out  (nent_out)
  );

endmodule

// ==== logic/read_output_stage.sv ====
`timescale 1ns/1ps

module read_output_stage #(
  parameter int RAM_WIDTH = 14               // Stub word width
) (
  input  logic                                  clkb,      // Shared clock
  input  logic                                  rstb,      // Clears the outputs
  input  logic                                  regceb,    // Output register enable
  input  logic [RAM_WIDTH-1:0]                  ram_data,  // Word from stage one
  input  logic [binned_memory_pkg::COUNT_W-1:0] bin_count, // Count from stage one
  output logic [RAM_WIDTH-1:0]                  doutb,     // Stored stub word
  output logic [binned_memory_pkg::COUNT_W-1:0] nent_out   // Entries in that bin
);

  //////////////////////////////////////////////////
  // Second pipeline stage
  //////////////////////////////////////////////////

  // Word and count share one enable and one reset, so the
  // downstream reader always sees a matched pair
  always_ff @(posedge clkb) begin
    if (rstb) begin
      doutb    <= '0;                        // Zero until first regceb
      nent_out <= '0;
    end else if (regceb) begin
      doutb    <= ram_data;                  // Two cycles after issue
      nent_out <= bin_count;
    end
  end

endmodule

// ==== logic/bin_count_table.sv ====
`timescale 1ns/1ps

module bin_count_table (
  input  logic                                    clkb,      // Shared clock
  input  logic                                    rstb,      // Clears every count
  input  binned_memory_pkg::count_wr_t            count_wr,  // Count write command
  input  logic                                    enb,       // Read enable, same as RAM
  input  binned_memory_pkg::mem_addr_t            addrb,     // Read address, slot unused
  output logic [binned_memory_pkg::COUNT_W-1:0]   bin_count  // Stage one count
);

  //////////////////////////////////////////////////
  // Count storage
  //////////////////////////////////////////////////

  // Small table in flops so the whole thing clears in one cycle
  logic [binned_memory_pkg::COUNT_W-1:0]
    counts [binned_memory_pkg::NUM_PAGES][binned_memory_pkg::NUM_BINS];

  always_ff @(posedge clkb) begin
    if (rstb) begin
      counts <= '{default: '0};              // Fresh event starts empty
    end else if (count_wr.we) begin
      counts[count_wr.page][count_wr.bin] <= count_wr.count;
    end
  end

  //////////////////////////////////////////////////
  // Registered read
  //////////////////////////////////////////////////

  // Loads on the same enable as the RAM read so word and count stay paired.
  // A write to this bin on the same edge is seen by the next read only
  always_ff @(posedge clkb) begin
    if (enb) begin
      bin_count <= counts[addrb.page][addrb.bin]; // Slot field ignored
    end
  end

endmodule

// ==== logic/bin_data_ram.sv ====
`timescale 1ns/1ps

module bin_data_ram #(
  parameter int RAM_WIDTH = 14               // 14 barrel PS, 15 barrel 2S and disk
) (
  input  logic                         clkb,     // Shared clock
  input  logic                         wea,      // Data write enable
  input  binned_memory_pkg::mem_addr_t addra,    // Write address
  input  logic [RAM_WIDTH-1:0]         dina,     // Stub word in
  input  logic                         enb,      // Read enable
  input  binned_memory_pkg::mem_addr_t addrb,    // Read address
  output logic [RAM_WIDTH-1:0]         ram_data  // Stage one read word
);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // Zero start for simulation only, no reset on the array
  logic [RAM_WIDTH-1:0] mem [binned_memory_pkg::DEPTH] = '{default: '0};

  logic [binned_memory_pkg::ADDR_W-1:0] wr_idx;  // Flat write index
  logic [binned_memory_pkg::ADDR_W-1:0] rd_idx;  // Flat read index

  assign wr_idx = addra;                     // Page.bin.slot packs to one word
  assign rd_idx = addrb;

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  always_ff @(posedge clkb) begin
    if (wea) begin
      mem[wr_idx] <= dina;                   // Visible to reads from next edge
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Separate process so a same-edge read of the written address
  // picks up the word that was there before the write
  always_ff @(posedge clkb) begin
    if (enb) begin
      ram_data <= mem[rd_idx];               // Hold last word while enb low
    end
  end

endmodule

// ==== logic/binned_memory_pkg.sv ====
package binned_memory_pkg;

  //////////////////////////////////////////////////
  // Memory geometry
  //////////////////////////////////////////////////

  localparam int NUM_PAGES = 8;              // Event pages held at once
  localparam int NUM_BINS  = 8;              // Bins per page
  localparam int NUM_SLOTS = 16;             // Stub slots per bin

  localparam int PAGE_W = 3;                 // Page number width
  localparam int BIN_W  = 3;                 // Bin number width
  localparam int SLOT_W = 4;                 // Slot number width

  localparam int ADDR_W = PAGE_W + BIN_W + SLOT_W;       // Full word address, 10 bits
  localparam int DEPTH  = NUM_PAGES * NUM_BINS * NUM_SLOTS; // 1024 RAM words

  // Four bits hold 0 to 15, one short of a full bin
  localparam int COUNT_W = 4;                // Entry count width

  //////////////////////////////////////////////////
  // Bus types
  //////////////////////////////////////////////////

  // Page sits on top so one page is one contiguous block of the RAM
  typedef struct packed {
    logic [PAGE_W-1:0] page;                 // Event page
    logic [BIN_W-1:0]  bin;                  // Bin in page
    logic [SLOT_W-1:0] slot;                 // Slot in bin
  } mem_addr_t;

  typedef struct packed {
    logic               we;                  // Count write strobe
    logic [PAGE_W-1:0]  page;                // Target page
    logic [BIN_W-1:0]   bin;                 // Target bin
    logic [COUNT_W-1:0] count;               // New entry count
  } count_wr_t;

endpackage
